//--- Bender.yml
package:
  name: video_out

sources:
  - design/video_pkg.sv
  - design/vid_timing_gen.sv
  - design/blank_to_count.sv
  - design/pattern_gen.sv
  - design/wb_ctrl_regs.sv
  - design/video_top.sv
  - target: test
    files:
      - bench/video_properties.sv
      - bench/video_tb.sv

//--- bench/video_properties.sv
// Bound checks on the Wishbone handshake and the output raster of video_top.
// All properties are disabled while reset is asserted.

`timescale 1ns/1ps

module video_properties (
  input logic i_Clk,
  input logic i_arst_n,
  input logic i_wb_cyc,
  input logic i_wb_stb,
  input logic o_wb_ack,
  input logic o_hsync_n,
  input logic o_vsync_n,
  input logic o_de,
  input logic i_enable
);

  // Number of property failures, summed into the testbench result
  int unsigned fail_cnt = 0;

  // Ack answers a request seen in the previous cycle
  ack_after_req: assert property (@(posedge i_Clk) disable iff (!i_arst_n)
    o_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
  else
  begin
    fail_cnt++;
    $error("ack without a request in the previous cycle");
  end

  ack_one_cycle: assert property (@(posedge i_Clk) disable iff (!i_arst_n)
    o_wb_ack |=> !o_wb_ack)
  else
  begin
    fail_cnt++;
    $error("ack held for two cycles");
  end

  // Active video never overlaps a sync pulse
  de_outside_sync: assert property (@(posedge i_Clk) disable iff (!i_arst_n)
    o_de |-> (o_hsync_n && o_vsync_n))
  else
  begin
    fail_cnt++;
    $error("de high during a sync pulse");
  end

  de_needs_enable: assert property (@(posedge i_Clk) disable iff (!i_arst_n)
    !i_enable |-> !$rose(o_de))
  else
  begin
    fail_cnt++;
    $error("de rose while the raster was disabled");
  end

endmodule

bind video_top video_properties props_i (
  .i_Clk     (i_Clk),
  .i_arst_n  (i_arst_n),
  .i_wb_cyc  (i_wb_cyc),
  .i_wb_stb  (i_wb_stb),
  .o_wb_ack  (o_wb_ack),
  .o_hsync_n (o_hsync_n),
  .o_vsync_n (o_vsync_n),
  .o_de      (o_de),
  .i_enable  (cfg.enable)
);

//--- bench/video_tb.sv
// Testbench for video_top covering register access, raster geometry and all four patterns.
// The pixel monitor keeps its own column and row and expects a new pattern only at a
// frame start. Bound property failures are added to the error count at the end.

`timescale 1ns/1ps

module video_tb;

  import video_pkg::*;

  localparam int FRAME_CYC = H_TOTAL * V_TOTAL;
  // Six frames of video plus room for reset and register traffic
  localparam int WATCHDOG_NS = (6 * FRAME_CYC + 20000) * 10;

  logic                i_Clk;
  logic                i_arst_n;
  logic                i_wb_cyc;
  logic                i_wb_stb;
  logic                i_wb_we;
  logic [WB_ADR_W-1:0] i_wb_adr;
  logic [WB_DAT_W-1:0] i_wb_dat;
  logic [WB_DAT_W-1:0] o_wb_dat;
  logic                o_wb_ack;
  logic                o_hsync_n;
  logic                o_vsync_n;
  logic                o_de;
  rgb_t                o_rgb;

  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          mark = 0;
  logic [31:0] seed = 32'h4a3a6802;
  logic [31:0] frames_base;
  int          vs_base;

  // Monitor state, all sampled on the falling clock edge
  int       cyc = 0;
  int       col = 0;
  int       row = 0;
  int       de_cnt = 0;
  int       frames_seen = 0;
  int       t_de_rise = 0;
  int       t_de_fall = 0;
  int       t_hs_fall = 0;
  int       t_vs_fall = 0;
  logic     prev_de = 1'b0;
  logic     prev_hs = 1'b1;
  logic     prev_vs = 1'b1;
  pattern_e pend_pat = PAT_SOLID;
  pattern_e cur_pat = PAT_SOLID;
  rgb_t     pend_col = '0;
  rgb_t     cur_col = '0;
  rgb_t     exp_px;

  video_top dut_i (.*);

  initial
  begin
    i_Clk = 1'b0;
    forever #5 i_Clk = ~i_Clk;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Reference pixel for one active position
  function automatic rgb_t expect_pixel(input pattern_e pat, input rgb_t color,
                                        input int c, input int r);
    rgb_t p;
    p = '0;
    case (pat)
      PAT_SOLID:
        p = color;
      PAT_BARS:
        case (c / 80)
          0: p = 24'hffffff;
          1: p = 24'hffff00;
          2: p = 24'h00ffff;
          3: p = 24'h00ff00;
          4: p = 24'hff00ff;
          5: p = 24'hff0000;
          6: p = 24'h0000ff;
          default: p = 24'h000000;
        endcase
      PAT_CHECKER:
        if (c[5] != r[5])
          p = 24'hffffff;
      PAT_GRADIENT:
        p = {8'(c), 8'(r), 8'h00};
      default:
        p = '0;
    endcase
    return p;
  endfunction

  task automatic check_int(input int got, input int exp, input string what);
    checks++;
    assert (got == exp)
    else
    begin
      errors++;
      $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // One classic cycle, request driven 1 ns after the clock edge
  task automatic wb_cycle(input logic we, input logic [WB_ADR_W-1:0] adr,
                          input logic [31:0] wdat, output logic [31:0] rdat);
    int n;
    @(posedge i_Clk);
    #1;
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_adr = adr;
    i_wb_dat = wdat;
    n = 0;
    rdat = '0;
    do
    begin
      @(posedge i_Clk);
      #1;
      n++;
    end
    while (!o_wb_ack && n < 16);
    if (o_wb_ack)
    begin
      rdat = o_wb_dat;
      // A registered master sees ack only at the next edge, so the request spans it
      @(posedge i_Clk);
      #1;
    end
    else
    begin
      errors++;
      $display("Wishbone cycle to address %0d got no ack within 16 clocks", adr);
    end
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [31:0] dat);
    logic [31:0] dummy;
    wb_cycle(1'b1, adr, dat, dummy);
  endtask

  task automatic check_read(input logic [WB_ADR_W-1:0] adr, input logic [31:0] exp,
                            input string what);
    logic [31:0] rd;
    wb_cycle(1'b0, adr, '0, rd);
    checks++;
    assert (rd == exp)
    else
    begin
      errors++;
      $display("FAIL %0t: %s read %h, expected %h", $time, what, rd, exp);
    end
  endtask

  // Returns in the vertical back porch after frame n-1 has shown its vsync
  task automatic wait_frame_end(input int n);
    while (!(frames_seen >= n && o_vsync_n))
      @(negedge i_Clk);
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - mark);
    mark = errors;
  endtask

  // Pixel and geometry monitor
  always @(negedge i_Clk)
  begin
    cyc++;
    if (o_de)
    begin
      if (!prev_de)
      begin
        // Row zero marks a frame start, where the new pattern takes over
        if (row == 0)
        begin
          cur_pat = pend_pat;
          cur_col = pend_col;
        end
        else
          check_int(cyc - t_de_rise, H_TOTAL, "line period");
        t_de_rise = cyc;
        de_cnt = 0;
      end
      exp_px = expect_pixel(cur_pat, cur_col, col, row);
      checks++;
      assert (o_rgb == exp_px)
      else
      begin
        errors++;
        $display("FAIL %0t: pixel (%0d,%0d) is %h, expected %h", $time, col, row, o_rgb, exp_px);
      end
      col++;
      de_cnt++;
    end
    if (prev_de && !o_de)
    begin
      check_int(de_cnt, H_ACTIVE, "active pixels per line");
      t_de_fall = cyc;
      col = 0;
      row++;
    end
    if (prev_hs && !o_hsync_n)
    begin
      t_hs_fall = cyc;
      // Lines in vertical blank have no de edge to measure from
      if (cyc - t_de_fall < H_TOTAL)
        check_int(cyc - t_de_fall, H_FRONT, "hsync start after de");
    end
    if (!prev_hs && o_hsync_n)
      check_int(cyc - t_hs_fall, H_SYNC, "hsync width");
    if (prev_vs && !o_vsync_n)
    begin
      check_int(row, V_ACTIVE, "active lines per frame");
      t_vs_fall = cyc;
      row = 0;
      frames_seen++;
    end
    if (!prev_vs && o_vsync_n)
      check_int(cyc - t_vs_fall, V_SYNC * H_TOTAL, "vsync width");
    prev_de = o_de;
    prev_hs = o_hsync_n;
    prev_vs = o_vsync_n;
  end

  initial
  begin
    i_arst_n = 1'b0;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
    i_wb_adr = '0;
    i_wb_dat = '0;
    repeat (8) @(posedge i_Clk);
    #1;
    i_arst_n = 1'b1;

    // Raster stays idle until the host enables it
    repeat (1000)
    begin
      @(negedge i_Clk);
      checks++;
      assert (!o_de && o_hsync_n && o_vsync_n)
      else
      begin
        errors++;
        $display("FAIL %0t: raster active before enable", $time);
      end
    end
    check_read(REG_CTRL, 32'h0, "CTRL after reset");
    check_read(REG_FRAMES, 32'h0, "FRAMES after reset");
    finish_test("reset state");

    seed = lcg_next(seed);
    wb_write(REG_COLOR, seed);
    check_read(REG_COLOR, {8'h00, seed[23:0]}, "COLOR readback");
    wb_write(REG_CTRL, 32'h4);
    check_read(REG_CTRL, 32'h4, "CTRL readback");
    wb_write(REG_FRAMES, 32'h1234);
    check_read(REG_FRAMES, 32'h0, "FRAMES after write");
    check_read(4'd5, 32'h0, "unmapped word 5");
    finish_test("register access");

    // Frame 0 is solid and also carries the geometry checks
    seed = lcg_next(seed);
    pend_col = seed[31:8];
    pend_pat = PAT_SOLID;
    wb_write(REG_COLOR, {8'h00, seed[31:8]});
    wb_write(REG_CTRL, 32'h1);
    wait_frame_end(1);
    finish_test("raster geometry and solid colour");

    // Each pattern is written in vertical blank and shown for one frame
    pend_pat = PAT_BARS;
    wb_write(REG_CTRL, 32'h3);
    wait_frame_end(2);
    pend_pat = PAT_CHECKER;
    wb_write(REG_CTRL, 32'h5);
    wait_frame_end(3);
    pend_pat = PAT_GRADIENT;
    wb_write(REG_CTRL, 32'h7);
    wait_frame_end(4);
    finish_test("bars checker gradient");

    // Mid-frame change, the rest of frame 4 must stay gradient
    while (row < V_ACTIVE / 2)
      @(negedge i_Clk);
    wb_cycle(1'b0, REG_FRAMES, '0, frames_base);
    vs_base = frames_seen;
    seed = lcg_next(seed);
    pend_col = seed[31:8];
    pend_pat = PAT_SOLID;
    wb_write(REG_COLOR, {8'h00, seed[31:8]});
    wb_write(REG_CTRL, 32'h1);
    wait_frame_end(5);
    while (row < V_ACTIVE / 2)
      @(negedge i_Clk);
    check_read(REG_FRAMES, frames_base + 32'(frames_seen - vs_base), "FRAMES vs vsync count");
    finish_test("frame latching");

    errors += dut_i.props_i.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- build.f
design/video_pkg.sv
design/vid_timing_gen.sv
design/blank_to_count.sv
design/pattern_gen.sv
design/wb_ctrl_regs.sv
design/video_top.sv
bench/video_properties.sv
bench/video_tb.sv

//--- design/blank_to_count.sv
// Derives active column and row from the incoming blanking flags.
// Line and frame starts come from falling blank edges, so the source must
// assert both blanks before the first active pixel of every frame.
// Col and row read zero outside the active area.

`timescale 1ns/1ps

module blank_to_count (
  input  logic                i_Clk,
  input  logic                i_arst_n,
  input  video_pkg::raster_t  i_raster,
  output video_pkg::pix_pos_t o_pos
);

  import video_pkg::*;

  logic [COORD_W-1:0] col_q;
  logic [COORD_W-1:0] row_q;
  logic [COORD_W-1:0] col_cur;
  logic [COORD_W-1:0] row_cur;
  logic               active_cur;
  logic               line_start;
  logic               frame_start;
  logic               col_last;
  logic               row_last;

  assign active_cur = ~i_raster.hblank & ~i_raster.vblank;

  // The registered raster in o_pos doubles as the delayed copy for edge detection
  assign line_start  = o_pos.raster.hblank & ~i_raster.hblank;
  assign frame_start = o_pos.raster.vblank & ~i_raster.vblank;

  // Position of the pixel arriving now, with edges overriding the stored counts
  assign col_cur = line_start  ? '0 : col_q;
  assign row_cur = frame_start ? '0 : row_q;

  assign col_last = (col_cur == COORD_W'(H_ACTIVE - 1));
  assign row_last = (row_cur == COORD_W'(V_ACTIVE - 1));

  // col_q holds the next column, row_q the row of the current or next line
  always_ff @(posedge i_Clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      col_q <= '0;
      row_q <= '0;
    end
    else if (active_cur)
    begin
      if (col_last)
      begin
        col_q <= '0;
        // Row steps at the end of the line and wraps after the last line
        if (row_last)
          row_q <= '0;
        else
          row_q <= row_cur + 1'b1;
      end
      else
      begin
        col_q <= col_cur + 1'b1;
        row_q <= row_cur;
      end
    end
  end

  // One register stage keeps the position aligned with the delayed syncs
  always_ff @(posedge i_Clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_pos <= '{raster: RASTER_IDLE, active: 1'b0, first: 1'b0, col: '0, row: '0};
    end
    else
    begin
      o_pos.raster <= i_raster;
      o_pos.active <= active_cur;
      // Both blanks fall together at position zero, which is the first pixel
      o_pos.first  <= frame_start & active_cur;
      o_pos.col    <= active_cur ? col_cur : '0;
      o_pos.row    <= active_cur ? row_cur : '0;
    end
  end

endmodule

//--- design/pattern_gen.sv
// Turns an active position into an RGB pixel for the selected test pattern.
// Pattern and colour are sampled at the first pixel of a frame, so changes
// made mid-frame appear from the next frame on.
// Pixel, de and syncs are registered together, one clock after the position.

`timescale 1ns/1ps

module pattern_gen (
  input  logic                  i_Clk,
  input  logic                  i_arst_n,
  input  video_pkg::video_cfg_t i_cfg,
  input  video_pkg::pix_pos_t   i_pos,
  output logic                  o_hsync_n,
  output logic                  o_vsync_n,
  output logic                  o_de,
  output video_pkg::rgb_t       o_rgb
);

  import video_pkg::*;

  pattern_e pat_q;
  rgb_t     color_q;
  pattern_e pat_cur;
  rgb_t     color_cur;
  logic [2:0] bar;
  rgb_t     pix;

  // The first pixel uses the live setting, later pixels the frame copy
  assign pat_cur   = i_pos.first ? i_cfg.pattern : pat_q;
  assign color_cur = i_pos.first ? i_cfg.color   : color_q;

  // Bar index 0 to 7 across the active line
  assign bar = 3'(i_pos.col / COORD_W'(BAR_W));

  always_ff @(posedge i_Clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      pat_q   <= PAT_SOLID;
      color_q <= '0;
    end
    else if (i_pos.first)
    begin
      pat_q   <= i_cfg.pattern;
      color_q <= i_cfg.color;
    end
  end

  always_comb
  begin
    pix = '0;
    case (pat_cur)
      PAT_SOLID:
        pix = color_cur;
      PAT_BARS:
      begin
        // White, yellow, cyan, green, magenta, red, blue, black
        // Red drops on bit 1, green on bit 2, blue on bit 0 of the index
        pix.red   = {8{~bar[1]}};
        pix.green = {8{~bar[2]}};
        pix.blue  = {8{~bar[0]}};
      end
      PAT_CHECKER:
      begin
        // 32 pixel squares, white where the column and row squares differ
        if (i_pos.col[5] ^ i_pos.row[5])
          pix = '{red: 8'hff, green: 8'hff, blue: 8'hff};
      end
      PAT_GRADIENT:
      begin
        pix.red   = i_pos.col[7:0];
        pix.green = i_pos.row[7:0];
      end
      default:
        pix = '0;
    endcase
  end

  always_ff @(posedge i_Clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_hsync_n <= 1'b1;
      o_vsync_n <= 1'b1;
      o_de      <= 1'b0;
      o_rgb     <= '0;
    end
    else
    begin
      o_hsync_n <= i_pos.raster.hsync_n;
      o_vsync_n <= i_pos.raster.vsync_n;
      o_de      <= i_pos.active;
      // Blanked pixels are black
      o_rgb     <= i_pos.active ? pix : '0;
    end
  end

endmodule

//--- design/vid_timing_gen.sv
// Free running raster timing for the fixed 640x480 geometry.
// Counters sit at zero while enable is clear; the raster output is then idle.
// The raster output lags the counters by one clock.

`timescale 1ns/1ps

module vid_timing_gen (
  input  logic                  i_Clk,
  input  logic                  i_arst_n,
  input  video_pkg::video_cfg_t i_cfg,
  output video_pkg::raster_t    o_raster,
  output logic                  o_frame_start
);

  import video_pkg::*;

  logic [COORD_W-1:0] h_cnt;
  logic [COORD_W-1:0] v_cnt;
  logic               h_last;
  logic               v_last;
  raster_t            raster_next;

  // Last pixel of a line and last line of a frame
  assign h_last = (h_cnt == COORD_W'(H_TOTAL - 1));
  assign v_last = (v_cnt == COORD_W'(V_TOTAL - 1));

  // Position zero is the first active pixel, so a frame begins when both are zero
  assign o_frame_start = i_cfg.enable && (h_cnt == '0) && (v_cnt == '0);

  // The horizontal counter wraps into the vertical one
  always_ff @(posedge i_Clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      h_cnt <= '0;
      v_cnt <= '0;
    end
    else if (!i_cfg.enable)
    begin
      // Parked at zero so that enabling starts a clean frame
      h_cnt <= '0;
      v_cnt <= '0;
    end
    else
    begin
      if (h_last)
      begin
        h_cnt <= '0;
        if (v_last)
          v_cnt <= '0;
        else
          v_cnt <= v_cnt + 1'b1;
      end
      else
      begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  // Each line and frame runs active, front porch, sync pulse, then back porch
  always_comb
  begin
    raster_next.hblank  = (h_cnt >= COORD_W'(H_ACTIVE));
    raster_next.vblank  = (v_cnt >= COORD_W'(V_ACTIVE));
    raster_next.hsync_n = !((h_cnt >= COORD_W'(H_SYNC_START)) &&
                            (h_cnt <  COORD_W'(H_SYNC_END)));
    raster_next.vsync_n = !((v_cnt >= COORD_W'(V_SYNC_START)) &&
                            (v_cnt <  COORD_W'(V_SYNC_END)));
  end

  // Registered flags, forced idle the cycle after enable drops
  always_ff @(posedge i_Clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
      o_raster <= RASTER_IDLE;
    else if (!i_cfg.enable)
      o_raster <= RASTER_IDLE;
    else
      o_raster <= raster_next;
  end

endmodule

//--- design/video_pkg.sv
// Shared definitions for the 640x480 at 60 Hz video output path.
// The raster geometry is fixed here; no other resolution is supported.
// Both syncs are active low, and blanking is active high.

package video_pkg;

  // Horizontal timing in pixel clocks, in raster order
  localparam int unsigned H_ACTIVE = 640;
  localparam int unsigned H_FRONT  = 16;
  localparam int unsigned H_SYNC   = 96;
  localparam int unsigned H_BACK   = 48;
  localparam int unsigned H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

  // Vertical timing in lines
  localparam int unsigned V_ACTIVE = 480;
  localparam int unsigned V_FRONT  = 10;
  localparam int unsigned V_SYNC   = 2;
  localparam int unsigned V_BACK   = 33;
  localparam int unsigned V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  // Sync pulse windows, first position inside and first position past the pulse
  localparam int unsigned H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int unsigned H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam int unsigned V_SYNC_START = V_ACTIVE + V_FRONT;
  localparam int unsigned V_SYNC_END   = V_SYNC_START + V_SYNC;

  // Counter width, wide enough for H_TOTAL-1 and V_TOTAL-1
  localparam int unsigned COORD_W = 10;

  // Width of one colour bar, eight bars across the active line
  localparam int unsigned BAR_W = H_ACTIVE / 8;

  // Wishbone widths and register decode
  localparam int unsigned WB_ADR_W    = 4;
  localparam int unsigned WB_DAT_W    = 32;
  localparam int unsigned REG_SEL_W   = 3;
  localparam int unsigned FRAME_CNT_W = 16;

  localparam logic [REG_SEL_W-1:0] REG_CTRL   = 3'd0;
  localparam logic [REG_SEL_W-1:0] REG_COLOR  = 3'd1;
  localparam logic [REG_SEL_W-1:0] REG_FRAMES = 3'd2;

  typedef enum logic [1:0] {
    PAT_SOLID    = 2'd0,
    PAT_BARS     = 2'd1,
    PAT_CHECKER  = 2'd2,
    PAT_GRADIENT = 2'd3
  } pattern_e;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  typedef struct packed {
    logic hsync_n;
    logic vsync_n;
    logic hblank;
    logic vblank;
  } raster_t;

  // Raster state while the output is disabled or in reset
  localparam raster_t RASTER_IDLE = '{hsync_n: 1'b1, vsync_n: 1'b1, hblank: 1'b1, vblank: 1'b1};

  typedef struct packed {
    raster_t            raster;
    logic               active;
    logic               first;
    logic [COORD_W-1:0] col;
    logic [COORD_W-1:0] row;
  } pix_pos_t;

  typedef struct packed {
    logic     enable;
    pattern_e pattern;
    rgb_t     color;
  } video_cfg_t;

endpackage

//--- design/video_top.sv
// Video output top level: register block plus a three stage pixel pipeline.
// Sync, de and pixel leave aligned, three clocks after the raster counters.
// Bus and video run on the single clock i_Clk.

`timescale 1ns/1ps

module video_top (
  input  logic                           i_Clk,
  input  logic                           i_arst_n,
  input  logic                           i_wb_cyc,
  input  logic                           i_wb_stb,
  input  logic                           i_wb_we,
  input  logic [video_pkg::WB_ADR_W-1:0] i_wb_adr,
  input  logic [video_pkg::WB_DAT_W-1:0] i_wb_dat,
  output logic [video_pkg::WB_DAT_W-1:0] o_wb_dat,
  output logic                           o_wb_ack,
  output logic                           o_hsync_n,
  output logic                           o_vsync_n,
  output logic                           o_de,
  output video_pkg::rgb_t                o_rgb
);

  import video_pkg::*;

  video_cfg_t cfg;
  raster_t    raster;
  pix_pos_t   pos;
  logic       frame_start;

  // Host registers, fed back the frame start pulse for the frame counter
  wb_ctrl_regs regs_i (
    .i_Clk         (i_Clk),
    .i_arst_n      (i_arst_n),
    .i_wb_cyc      (i_wb_cyc),
    .i_wb_stb      (i_wb_stb),
    .i_wb_we       (i_wb_we),
    .i_wb_adr      (i_wb_adr),
    .i_wb_dat      (i_wb_dat),
    .o_wb_dat      (o_wb_dat),
    .o_wb_ack      (o_wb_ack),
    .i_frame_start (frame_start),
    .o_cfg         (cfg)
  );

  // Stage 1, counters to sync and blank flags
  vid_timing_gen timing_i (
    .i_Clk         (i_Clk),
    .i_arst_n      (i_arst_n),
    .i_cfg         (cfg),
    .o_raster      (raster),
    .o_frame_start (frame_start)
  );

  // Stage 2, blank flags to active position
  blank_to_count count_i (
    .i_Clk    (i_Clk),
    .i_arst_n (i_arst_n),
    .i_raster (raster),
    .o_pos    (pos)
  );

  // Stage 3, position to pixel
  pattern_gen pattern_i (
    .i_Clk     (i_Clk),
    .i_arst_n  (i_arst_n),
    .i_cfg     (cfg),
    .i_pos     (pos),
    .o_hsync_n (o_hsync_n),
    .o_vsync_n (o_vsync_n),
    .o_de      (o_de),
    .o_rgb     (o_rgb)
  );

endmodule

//--- design/wb_ctrl_regs.sv
// Wishbone classic slave with the control, colour and frame count registers.
// Ack follows a request by one clock and lasts one clock; no wait states.
// Only address bits 2:0 are decoded, so the map repeats above word 7.
// Shares i_Clk with the video path; there is no clock crossing.

`timescale 1ns/1ps

module wb_ctrl_regs (
  input  logic                           i_Clk,
  input  logic                           i_arst_n,
  input  logic                           i_wb_cyc,
  input  logic                           i_wb_stb,
  input  logic                           i_wb_we,
  input  logic [video_pkg::WB_ADR_W-1:0] i_wb_adr,
  input  logic [video_pkg::WB_DAT_W-1:0] i_wb_dat,
  output logic [video_pkg::WB_DAT_W-1:0] o_wb_dat,
  output logic                           o_wb_ack,
  input  logic                           i_frame_start,
  output video_pkg::video_cfg_t          o_cfg
);

  import video_pkg::*;

  logic                   req;
  logic                   wr;
  logic [REG_SEL_W-1:0]   sel;
  logic [FRAME_CNT_W-1:0] frame_cnt;

  // A new request is one not already being acknowledged
  assign req = i_wb_cyc & i_wb_stb & ~o_wb_ack;
  assign wr  = req & i_wb_we;
  assign sel = i_wb_adr[REG_SEL_W-1:0];

  always_ff @(posedge i_Clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
      o_wb_ack <= 1'b0;
    else
      o_wb_ack <= req;
  end

  // Writes land on the same edge that raises ack
  always_ff @(posedge i_Clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_cfg <= '{enable: 1'b0, pattern: PAT_SOLID, color: '0};
    end
    else if (wr)
    begin
      case (sel)
        REG_CTRL:
        begin
          o_cfg.enable  <= i_wb_dat[0];
          o_cfg.pattern <= pattern_e'(i_wb_dat[2:1]);
        end
        REG_COLOR:
          o_cfg.color <= i_wb_dat[23:0];
        // FRAMES is read only and unmapped words are ignored
        default:
          o_cfg <= o_cfg;
      endcase
    end
  end

  // Counts frame starts and wraps at 16 bits
  always_ff @(posedge i_Clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
      frame_cnt <= '0;
    else if (i_frame_start)
      frame_cnt <= frame_cnt + 1'b1;
  end

  // Read data is only driven during the ack cycle, zero otherwise
  always_comb
  begin
    o_wb_dat = '0;
    if (o_wb_ack && !i_wb_we)
    begin
      case (sel)
        REG_CTRL:   o_wb_dat = WB_DAT_W'({o_cfg.pattern, o_cfg.enable});
        REG_COLOR:  o_wb_dat = WB_DAT_W'(o_cfg.color);
        REG_FRAMES: o_wb_dat = WB_DAT_W'(frame_cnt);
        default:    o_wb_dat = '0;
      endcase
    end
  end

endmodule
